//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal
TOP = conv_tb
FILELIST = src.f
OBJ_DIR = obj_dir
LOG = sim.log
PASS_MSG = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/cnn_pkg.sv
package cnn_pkg;

  // one weight or pixel is a signed byte.
  localparam int data_len = 8;
  localparam int taps = 9;
  localparam int rows_per_bank = 4;
  localparam int phase_count = 8;
  localparam int layer_stride = 32;
  localparam int phase_stride = 4;
  localparam int mem_depth = 160;
  localparam int addr_len = 8;
  localparam int acc_len = 20;

  localparam int word_len = taps * data_len;
  localparam int bank_len = rows_per_bank * word_len;
  localparam int prod_len = 2 * data_len;
  localparam int phase_len = $clog2(phase_count);
  localparam int lane_len = 3 * data_len;
  localparam int apb_data_len = 32;

  // register map.
  localparam logic [addr_len-1:0] reg_ctrl = 8'h00;
  localparam logic [addr_len-1:0] reg_status = 8'h04;
  localparam logic [addr_len-1:0] reg_waddr = 8'h08;
  localparam logic [addr_len-1:0] reg_wlane0 = 8'h10;
  localparam logic [addr_len-1:0] reg_wlane1 = 8'h14;
  localparam logic [addr_len-1:0] reg_wlane2 = 8'h18;
  localparam logic [addr_len-1:0] reg_pix0 = 8'h20;
  localparam logic [addr_len-1:0] reg_pix1 = 8'h24;
  localparam logic [addr_len-1:0] reg_pix2 = 8'h28;
  localparam logic [addr_len-1:0] reg_res0 = 8'h30;
  localparam logic [addr_len-1:0] reg_res1 = 8'h34;
  localparam logic [addr_len-1:0] reg_res2 = 8'h38;
  localparam logic [addr_len-1:0] reg_res3 = 8'h3C;

  // codes 5 to 7 are not layers and are refused at the register port.
  typedef enum logic [2:0] {
    LAYER0 = 3'd0,
    LAYER1 = 3'd1,
    LAYER2 = 3'd2,
    LAYER3 = 3'd3,
    AFFINE = 3'd4
  } layer_e;

  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    MAC,
    DONE
  } seq_state_e;

  typedef struct packed {
    logic [addr_len-1:0] paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [apb_data_len-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [apb_data_len-1:0] prdata;
    logic pready;
    logic pslverr;
  } apb_rsp_t;

  typedef struct packed {
    layer_e layer;
    logic [phase_len-1:0] phase;
  } job_t;

  typedef struct packed {
    logic en;
    logic [addr_len-1:0] addr;
    logic [word_len-1:0] data;
  } weight_wr_t;

  typedef struct packed {
    logic signed [acc_len-1:0] sum3;
    logic signed [acc_len-1:0] sum2;
    logic signed [acc_len-1:0] sum1;
    logic signed [acc_len-1:0] sum0;
  } mac_result_t;

endpackage

//--- design/apb_regs.sv
module apb_regs (
  input  logic                          clk,
  input  logic                          arst_n,
  input  cnn_pkg::apb_req_t             req,
  output cnn_pkg::apb_rsp_t             rsp,
  input  logic                          busy,
  input  logic                          done_pulse,
  input  cnn_pkg::mac_result_t          result,
  output logic                          start,
  output cnn_pkg::job_t                 job,
  output cnn_pkg::weight_wr_t           wr,
  output logic [cnn_pkg::word_len-1:0]  pixels
);

  import cnn_pkg::*;

  logic access;
  logic mapped;
  logic ctrl_hit;
  logic layer_bad;
  logic err;
  logic write_ok;
  logic [apb_data_len-1:0] rdata;

  job_t ctrl_q;
  logic done_q;
  logic [addr_len-1:0] waddr;
  logic [lane_len-1:0] lane0, lane1, lane2;
  logic [lane_len-1:0] pix0, pix1, pix2;

  assign access = req.psel && req.penable;

  always_comb begin
    case (req.paddr)
      reg_ctrl, reg_status, reg_waddr,
      reg_wlane0, reg_wlane1, reg_wlane2,
      reg_pix0, reg_pix1, reg_pix2,
      reg_res0, reg_res1, reg_res2, reg_res3: mapped = 1'b1;
      default: mapped = 1'b0;
    endcase
  end

  assign ctrl_hit = (req.paddr == reg_ctrl);
  assign layer_bad = (req.pwdata[2:0] > 3'(AFFINE));
  assign err = access && (!mapped || (req.pwrite && ctrl_hit && (layer_bad || busy)));
  assign write_ok = access && req.pwrite && !err;

  assign start = write_ok && ctrl_hit;
  assign job = '{layer: layer_e'(req.pwdata[2:0]), phase: req.pwdata[6:4]};

  // the lane 2 write completes the word and commits it.
  assign wr = '{
    en:   write_ok && (req.paddr == reg_wlane2),
    addr: waddr,
    data: {req.pwdata[lane_len-1:0], lane1, lane0}
  };

  assign pixels = {pix2, pix1, pix0};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_q <= '0;
      waddr <= '0;
      lane0 <= '0;
      lane1 <= '0;
      lane2 <= '0;
      pix0 <= '0;
      pix1 <= '0;
      pix2 <= '0;
    end else if (write_ok) begin
      case (req.paddr)
        reg_ctrl: ctrl_q <= job;
        reg_waddr: waddr <= req.pwdata[addr_len-1:0];
        reg_wlane0: lane0 <= req.pwdata[lane_len-1:0];
        reg_wlane1: lane1 <= req.pwdata[lane_len-1:0];
        reg_wlane2: begin
          lane2 <= req.pwdata[lane_len-1:0];
          waddr <= waddr + 1'b1;
        end
        reg_pix0: pix0 <= req.pwdata[lane_len-1:0];
        reg_pix1: pix1 <= req.pwdata[lane_len-1:0];
        reg_pix2: pix2 <= req.pwdata[lane_len-1:0];
        default: ;
      endcase
    end
  end

  // done is sticky until the next accepted start.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      done_q <= 1'b0;
    end else if (start) begin
      done_q <= 1'b0;
    end else if (done_pulse) begin
      done_q <= 1'b1;
    end
  end

  always_comb begin
    rdata = '0;
    case (req.paddr)
      reg_ctrl: begin
        rdata[2:0] = ctrl_q.layer;
        rdata[6:4] = ctrl_q.phase;
      end
      reg_status: rdata[1:0] = {done_q, busy};
      reg_waddr: rdata[addr_len-1:0] = waddr;
      reg_wlane0: rdata[lane_len-1:0] = lane0;
      reg_wlane1: rdata[lane_len-1:0] = lane1;
      reg_wlane2: rdata[lane_len-1:0] = lane2;
      reg_pix0: rdata[lane_len-1:0] = pix0;
      reg_pix1: rdata[lane_len-1:0] = pix1;
      reg_pix2: rdata[lane_len-1:0] = pix2;
      reg_res0: rdata = apb_data_len'(result.sum0);
      reg_res1: rdata = apb_data_len'(result.sum1);
      reg_res2: rdata = apb_data_len'(result.sum2);
      reg_res3: rdata = apb_data_len'(result.sum3);
      default: rdata = '0;
    endcase
  end

  assign rsp = '{prdata: rdata, pready: 1'b1, pslverr: err};

endmodule

//--- design/conv_engine_top.sv
module conv_engine_top (
  input  logic               clk,
  input  logic               arst_n,
  input  cnn_pkg::apb_req_t  apb_req,
  output cnn_pkg::apb_rsp_t  apb_rsp
);

  import cnn_pkg::*;

  logic start;
  job_t job_cmd;
  job_t job;
  weight_wr_t wr;
  logic [word_len-1:0] pixels;
  logic [bank_len-1:0] bank;
  logic bank_valid;
  logic load;
  logic mac_start;
  logic mac_done;
  mac_result_t result;
  logic busy;
  logic done_pulse;

  apb_regs u_apb_regs (
    .clk        (clk),
    .arst_n     (arst_n),
    .req        (apb_req),
    .rsp        (apb_rsp),
    .busy       (busy),
    .done_pulse (done_pulse),
    .result     (result),
    .start      (start),
    .job        (job_cmd),
    .wr         (wr),
    .pixels     (pixels)
  );

  layer_sequencer u_layer_sequencer (
    .clk        (clk),
    .arst_n     (arst_n),
    .start      (start),
    .job_in     (job_cmd),
    .bank_valid (bank_valid),
    .mac_done   (mac_done),
    .load       (load),
    .job        (job),
    .mac_start  (mac_start),
    .busy       (busy),
    .done_pulse (done_pulse)
  );

  weight_store u_weight_store (
    .clk    (clk),
    .arst_n (arst_n),
    .load   (load),
    .job    (job),
    .wr     (wr),
    .valid  (bank_valid),
    .bank   (bank)
  );

  conv_mac u_conv_mac (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (mac_start),
    .bank   (bank),
    .pixels (pixels),
    .done   (mac_done),
    .result (result)
  );

endmodule

//--- design/conv_mac.sv
module conv_mac (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          start,
  input  logic [cnn_pkg::bank_len-1:0]  bank,
  input  logic [cnn_pkg::word_len-1:0]  pixels,
  output logic                          done,
  output cnn_pkg::mac_result_t          result
);

  import cnn_pkg::*;

  logic signed [prod_len-1:0] prod [rows_per_bank][taps];
  logic signed [acc_len-1:0] row_sum [rows_per_bank];
  logic [1:0] vld;

  // stage 1: every weight of the bank times its window pixel.
  always_ff @(posedge clk) begin
    for (int r = 0; r < rows_per_bank; r++) begin
      for (int t = 0; t < taps; t++) begin
        prod[r][t] <= $signed(bank[(r * taps + t) * data_len +: data_len]) *
                      $signed(pixels[t * data_len +: data_len]);
      end
    end
  end

  // nine products of at most 2^14 each fit well inside the accumulator.
  always_comb begin
    for (int r = 0; r < rows_per_bank; r++) begin
      row_sum[r] = '0;
      for (int t = 0; t < taps; t++) begin
        row_sum[r] = row_sum[r] + acc_len'(prod[r][t]);
      end
    end
  end

  // stage 2: the four row sums.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result <= '0;
    end else begin
      result.sum0 <= row_sum[0];
      result.sum1 <= row_sum[1];
      result.sum2 <= row_sum[2];
      result.sum3 <= row_sum[3];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld <= '0;
    end else begin
      vld <= {vld[0], start};
    end
  end

  assign done = vld[1];

endmodule

//--- design/layer_sequencer.sv
module layer_sequencer (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           start,
  input  cnn_pkg::job_t  job_in,
  input  logic           bank_valid,
  input  logic           mac_done,
  output logic           load,
  output cnn_pkg::job_t  job,
  output logic           mac_start,
  output logic           busy,
  output logic           done_pulse
);

  import cnn_pkg::*;

  seq_state_e state;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state <= LOAD;
          end
        end
        LOAD: begin
          if (bank_valid) begin
            state <= MAC;
          end
        end
        MAC: begin
          if (mac_done) begin
            state <= DONE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // the job is held for the whole run so the bank address stays put.
  always_ff @(posedge clk) begin
    if ((state == IDLE) && start) begin
      job <= job_in;
    end
  end

  assign load = (state != IDLE);
  assign busy = (state != IDLE);
  // valid only rises once per load, and the state moves on the same edge.
  assign mac_start = (state == LOAD) && bank_valid;
  assign done_pulse = (state == DONE);

endmodule

//--- src.f
common/cnn_pkg.sv
weight_store/weight_mem.sv
weight_store/weight_store.sv
design/conv_mac.sv
design/layer_sequencer.sv
design/apb_regs.sv
design/conv_engine_top.sv
verification/conv_checker.sv
verification/conv_tb.sv

//--- verification/conv_checker.sv
module conv_checker (
  input  logic               clk,
  input  logic               arst_n,
  input  cnn_pkg::apb_req_t  req,
  input  cnn_pkg::apb_rsp_t  rsp,
  input  logic [2:0]         test_idx,
  input  logic               test_end,
  output int                 check_count,
  output int                 error_count
);

  import cnn_pkg::*;

  logic [word_len-1:0] model_mem [mem_depth];
  logic [lane_len-1:0] model_lane [3];
  logic [lane_len-1:0] model_pix [3];
  logic [addr_len-1:0] model_waddr;
  logic [31:0] model_ctrl;
  logic [31:0] exp_res [4];
  logic pending;
  logic done_flag;
  int test_checks;
  int test_errors;

  function automatic string test_name(input logic [2:0] idx);
    case (idx)
      3'd0: return "reset_state";
      3'd1: return "weight_fill";
      3'd2: return "convolution";
      3'd3: return "invalid_layer";
      3'd4: return "start_busy";
      3'd5: return "unmapped_addr";
      default: return "unknown";
    endcase
  endfunction

  function automatic logic is_mapped(input logic [7:0] addr);
    case (addr)
      8'h00, 8'h04, 8'h08, 8'h10, 8'h14, 8'h18, 8'h20, 8'h24, 8'h28,
      8'h30, 8'h34, 8'h38, 8'h3C: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // one sum is a row's nine weights times the nine window pixels.
  function automatic int row_sum(input int word);
    logic [71:0] w;
    logic [71:0] p;
    logic signed [7:0] wt;
    logic signed [7:0] px;
    int acc;
    w = model_mem[word];
    p = {model_pix[2], model_pix[1], model_pix[0]};
    acc = 0;
    for (int k = 0; k < 9; k++) begin
      wt = w[8*k +: 8];
      px = p[8*k +: 8];
      acc = acc + int'(wt) * int'(px);
    end
    return acc;
  endfunction

  function automatic logic [31:0] expected_read(input logic [7:0] addr);
    logic [31:0] v;
    v = '0;
    case (addr)
      8'h00: v = model_ctrl;
      8'h04: v = {30'd0, done_flag, 1'b0};
      8'h08: v = {24'd0, model_waddr};
      8'h10: v = {8'd0, model_lane[0]};
      8'h14: v = {8'd0, model_lane[1]};
      8'h18: v = {8'd0, model_lane[2]};
      8'h20: v = {8'd0, model_pix[0]};
      8'h24: v = {8'd0, model_pix[1]};
      8'h28: v = {8'd0, model_pix[2]};
      8'h30: v = exp_res[0];
      8'h34: v = exp_res[1];
      8'h38: v = exp_res[2];
      8'h3C: v = exp_res[3];
      default: v = '0;
    endcase
    return v;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    test_checks++;
    if (exp !== act) begin
      error_count++;
      test_errors++;
      $display("Error %s %s: expected 0x%08h, actual 0x%08h",
               test_name(test_idx), what, exp, act);
    end
  endtask

  task automatic start_job(input logic [2:0] layer, input logic [2:0] phase);
    int base;
    base = int'(layer) * 32 + int'(phase) * 4;
    for (int r = 0; r < 4; r++) begin
      exp_res[r] = row_sum(base + r);
    end
    pending = 1'b1;
    done_flag = 1'b0;
  endtask

  task automatic apply_write(input logic [7:0] addr, input logic [31:0] data);
    case (addr)
      8'h00: begin
        model_ctrl = {25'd0, data[6:4], 1'b0, data[2:0]};
        start_job(data[2:0], data[6:4]);
      end
      8'h08: model_waddr = data[7:0];
      8'h10: model_lane[0] = data[23:0];
      8'h14: model_lane[1] = data[23:0];
      8'h18: begin
        model_lane[2] = data[23:0];
        if (model_waddr < mem_depth) begin
          model_mem[model_waddr] = {model_lane[2], model_lane[1], model_lane[0]};
        end
        model_waddr = model_waddr + 8'd1;
      end
      8'h20: model_pix[0] = data[23:0];
      8'h24: model_pix[1] = data[23:0];
      8'h28: model_pix[2] = data[23:0];
      default: ;
    endcase
  endtask

  task automatic check_transfer();
    logic exp_err;
    exp_err = !is_mapped(req.paddr);
    if (req.pwrite && (req.paddr == 8'h00) && ((req.pwdata[2:0] > 3'd4) || pending)) begin
      exp_err = 1'b1;
    end
    if (!rsp.pready) begin
      error_count++;
      test_errors++;
      $display("pready was low in an access cycle at address 0x%02h", req.paddr);
    end
    check_value($sformatf("pslverr at 0x%02h", req.paddr), 32'(exp_err), 32'(rsp.pslverr));
    if (!req.pwrite) begin
      // while a job runs the status reads busy until it turns into done.
      if ((req.paddr == 8'h04) && pending && (rsp.prdata == 32'h2)) begin
        pending = 1'b0;
        done_flag = 1'b1;
      end else if ((req.paddr == 8'h04) && pending) begin
        check_value("status", 32'h1, rsp.prdata);
      end else begin
        check_value($sformatf("read 0x%02h", req.paddr), expected_read(req.paddr), rsp.prdata);
      end
    end else if (!exp_err) begin
      apply_write(req.paddr, req.pwdata);
    end
  endtask

  task automatic reset_model();
    for (int i = 0; i < mem_depth; i++) begin
      model_mem[i] = '0;
    end
    for (int i = 0; i < 4; i++) begin
      exp_res[i] = '0;
    end
    model_lane = '{default: '0};
    model_pix = '{default: '0};
    model_waddr = '0;
    model_ctrl = '0;
    pending = 1'b0;
    done_flag = 1'b0;
    test_checks = 0;
    test_errors = 0;
  endtask

  // sampled mid-cycle, where the bus and the read data are settled.
  always @(negedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reset_model();
    end else begin
      if (req.psel && req.penable) begin
        check_transfer();
      end
      if (test_end) begin
        $display("test %-14s %0d checks, %0d errors", test_name(test_idx),
                 test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
      end
    end
  end

endmodule

//--- verification/conv_tb.sv
module conv_tb;

  import cnn_pkg::*;

  localparam int timeout_cycles = 8000;
  localparam int job_count = 40;

  logic clk;
  logic arst_n;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  logic [2:0] test_idx;
  logic test_end;
  int check_count;
  int error_count;
  int cycle_count = 0;
  logic [15:0] lfsr_q;

  conv_engine_top DUT (
    .clk     (clk),
    .arst_n  (arst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  conv_checker u_checker (
    .clk         (clk),
    .arst_n      (arst_n),
    .req         (apb_req),
    .rsp         (apb_rsp),
    .test_idx    (test_idx),
    .test_end    (test_end),
    .check_count (check_count),
    .error_count (error_count)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("Checks failed");
      $finish;
    end
  end

  // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11, one step per bit.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [23:0] random_lane();
    logic [31:0] v;
    v = rand_bits(24);
    return v[23:0];
  endfunction

  // each transfer starts 2 units after a rising edge and leaves the bus there.
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    apb_req.paddr = addr;
    apb_req.pwrite = 1'b1;
    apb_req.pwdata = data;
    apb_req.psel = 1'b1;
    apb_req.penable = 1'b0;
    @(posedge clk);
    #2;
    apb_req.penable = 1'b1;
    @(posedge clk);
    #2;
    apb_req.psel = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    apb_req.paddr = addr;
    apb_req.pwrite = 1'b0;
    apb_req.psel = 1'b1;
    apb_req.penable = 1'b0;
    @(posedge clk);
    #2;
    apb_req.penable = 1'b1;
    @(negedge clk);
    data = apb_rsp.prdata;
    @(posedge clk);
    #2;
    apb_req.psel = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic finish_test();
    test_end = 1'b1;
    @(posedge clk);
    #2;
    test_end = 1'b0;
    test_idx = test_idx + 3'd1;
  endtask

  task automatic wait_done();
    logic [31:0] st;
    st = '0;
    while (st[1] == 1'b0) begin
      apb_read(reg_status, st);
    end
  endtask

  task automatic read_results();
    logic [31:0] rd;
    for (int k = 0; k < 4; k++) begin
      apb_read(reg_res0 + 8'(4 * k), rd);
    end
  endtask

  task automatic set_pixels(input logic [71:0] pix);
    apb_write(reg_pix0, {8'd0, pix[23:0]});
    apb_write(reg_pix1, {8'd0, pix[47:24]});
    apb_write(reg_pix2, {8'd0, pix[71:48]});
  endtask

  task automatic run_job(input logic [2:0] layer, input logic [2:0] phase,
                         input logic [71:0] pix);
    set_pixels(pix);
    apb_write(reg_ctrl, {25'd0, phase, 1'b0, layer});
    wait_done();
    read_results();
  endtask

  task automatic fill_weights();
    logic [71:0] word;
    logic [31:0] rd;
    apb_write(reg_waddr, 32'd0);
    for (int w = 0; w < mem_depth; w++) begin
      // the last AFFINE bank carries the signed extremes.
      if (w == 156) begin
        word = {9{8'h80}};
      end else if (w == 157) begin
        word = {9{8'h7F}};
      end else if (w == 158) begin
        word = {8'h80, {4{16'h7F80}}};
      end else begin
        word = {random_lane(), random_lane(), random_lane()};
      end
      apb_write(reg_wlane0, {8'd0, word[23:0]});
      apb_write(reg_wlane1, {8'd0, word[47:24]});
      apb_write(reg_wlane2, {8'd0, word[71:48]});
    end
    apb_read(reg_waddr, rd);
  endtask

  task automatic convolution_jobs();
    logic [31:0] v;
    logic [2:0] layer;
    logic [2:0] phase;
    run_job(3'd4, 3'd7, {9{8'h80}});
    run_job(3'd4, 3'd7, {9{8'h7F}});
    for (int j = 2; j < job_count; j++) begin
      v = rand_bits(3);
      layer = v[2:0];
      if (layer > 3'd4) begin
        layer = layer - 3'd4;
      end
      v = rand_bits(3);
      phase = v[2:0];
      run_job(layer, phase, {random_lane(), random_lane(), random_lane()});
    end
  endtask

  task automatic invalid_layers();
    logic [31:0] rd;
    logic [31:0] v;
    for (int code = 5; code < 8; code++) begin
      v = rand_bits(3);
      apb_write(reg_ctrl, {25'd0, v[2:0], 1'b0, 3'(code)});
      apb_read(reg_status, rd);
    end
    apb_read(reg_ctrl, rd);
  endtask

  task automatic start_while_busy();
    logic [31:0] rd;
    for (int i = 0; i < 2; i++) begin
      set_pixels({random_lane(), random_lane(), random_lane()});
      apb_write(reg_ctrl, {25'd0, 3'd2, 1'b0, 3'(i + 1)});
      apb_write(reg_ctrl, {25'd0, 3'd7, 1'b0, 3'd4});
      wait_done();
      apb_read(reg_ctrl, rd);
      read_results();
    end
  endtask

  task automatic unmapped_access();
    logic [31:0] rd;
    logic [31:0] v;
    logic [7:0] addr;
    for (int i = 0; i < 11; i++) begin
      if (i < 3) begin
        addr = 8'h0C + 8'(16 * i);
      end else begin
        v = rand_bits(8);
        addr = v[7:0] | 8'h40;
      end
      apb_write(addr, rand_bits(32));
      apb_read(addr, rd);
    end
  endtask

  initial begin
    logic [31:0] rd;
    lfsr_q = 16'd72;
    arst_n = 1'b0;
    apb_req = '0;
    test_idx = '0;
    test_end = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    arst_n = 1'b1;
    @(posedge clk);
    #2;
    apb_read(reg_status, rd);
    apb_read(reg_waddr, rd);
    read_results();
    finish_test();
    fill_weights();
    finish_test();
    convolution_jobs();
    finish_test();
    invalid_layers();
    finish_test();
    start_while_busy();
    finish_test();
    unmapped_access();
    finish_test();
    @(posedge clk);
    $display("Totals: %0d checks, %0d errors", check_count, error_count);
    if ((error_count == 0) && (check_count > 0)) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- weight_store/weight_mem.sv
module weight_mem (
  input  logic                          clk,
  input  cnn_pkg::weight_wr_t           wr,
  input  logic [cnn_pkg::addr_len-1:0]  addr,
  output logic [cnn_pkg::word_len-1:0]  q
);

  import cnn_pkg::*;

  // each word is one kernel row, weight k in bits 8k+7:8k.
  logic [word_len-1:0] mem [mem_depth];

  // addresses past the last word are dropped on write.
  always_ff @(posedge clk) begin
    if (wr.en && (wr.addr < mem_depth)) begin
      mem[wr.addr] <= wr.data;
    end
  end

  always_ff @(posedge clk) begin
    q <= mem[addr];
  end

endmodule

//--- weight_store/weight_store.sv
module weight_store (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          load,
  input  cnn_pkg::job_t                 job,
  input  cnn_pkg::weight_wr_t           wr,
  output logic                          valid,
  output logic [cnn_pkg::bank_len-1:0]  bank
);

  import cnn_pkg::*;

  logic [addr_len-1:0] layer_off;
  logic [addr_len-1:0] base_addr;
  logic [addr_len-1:0] rd_addr;
  logic [word_len-1:0] rd_data;
  logic [2:0] step;
  logic [1:0] row;
  logic capture;

  weight_mem u_weight_mem (
    .clk  (clk),
    .wr   (wr),
    .addr (rd_addr),
    .q    (rd_data)
  );

  always_comb begin
    case (job.layer)
      LAYER0: layer_off = addr_len'(0 * layer_stride);
      LAYER1: layer_off = addr_len'(1 * layer_stride);
      LAYER2: layer_off = addr_len'(2 * layer_stride);
      LAYER3: layer_off = addr_len'(3 * layer_stride);
      AFFINE: layer_off = addr_len'(4 * layer_stride);
      default: layer_off = '0;
    endcase
  end

  assign base_addr = layer_off + addr_len'(job.phase * phase_stride);

  // step 0 issues the base address, steps 1 to 3 walk the next rows.
  // read data lags the address by one cycle, so rows land at steps 2 to 5.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      step <= '0;
      rd_addr <= '0;
      valid <= 1'b0;
    end else if (!load) begin
      step <= '0;
      rd_addr <= base_addr;
      valid <= 1'b0;
    end else begin
      if (step < 3'd6) begin
        step <= step + 3'd1;
      end
      if (step == 3'd0) begin
        rd_addr <= base_addr;
      end else if (step < 3'd4) begin
        rd_addr <= rd_addr + 1'b1;
      end
      if (step == 3'd5) begin
        valid <= 1'b1;
      end
    end
  end

  assign capture = load && (step >= 3'd2) && (step <= 3'd5);
  // wraps 2..5 onto rows 0..3.
  assign row = step[1:0] - 2'd2;

  always_ff @(posedge clk) begin
    if (capture) begin
      bank[row * word_len +: word_len] <= rd_data;
    end
  end

endmodule
